//--- common/hudPkg.sv
package hudPkg;

    typedef logic [8:0]  pixelT;
    typedef logic [9:0]  scoreT;
    typedef logic [3:0]  levelT;
    typedef logic [3:0]  bcdDigitT;
    typedef logic [9:0]  respawnT;
    typedef logic [14:0] spriteAddrT;
    typedef logic [3:0]  pointsT;
    typedef logic [3:0]  glyphT;

    // every glyph in the sprite ROM is one 20 x 25 block, stored row by row.
    localparam int    GlyphWidth  = 20;
    localparam int    GlyphHeight = 25;
    localparam int    GlyphSize   = GlyphWidth * GlyphHeight;
    localparam glyphT GlyphL      = 4'd10; // digits 0 to 9 come first.
    localparam int    MaxScore    = 999;

    typedef enum logic {
        SpawnIdle,
        SpawnCount
    } spawnStateT;

    // true when the pixel lies inside the glyph box whose top-left corner is x0, y0.
    function automatic logic inBox(input pixelT px, input pixelT py,
                                   input pixelT x0, input pixelT y0);
        return (px >= x0) && (int'(px) < int'(x0) + GlyphWidth) &&
               (py >= y0) && (int'(py) < int'(y0) + GlyphHeight);
    endfunction

    function automatic spriteAddrT glyphAddr(input glyphT glyph, input pixelT dx,
                                             input pixelT dy);
        return spriteAddrT'(int'(glyph) * GlyphSize + int'(dy) * GlyphWidth + int'(dx));
    endfunction

endpackage

//--- common/scoreIf.sv
// score bundle shared by the keeper and the two HUD drawers.
interface scoreIf;

    hudPkg::scoreT    total;
    hudPkg::bcdDigitT hundreds;
    hudPkg::bcdDigitT tens;
    hudPkg::bcdDigitT ones;

    modport keeper (
        output total,
        output hundreds,
        output tens,
        output ones
    );

    modport viewer (
        input total,
        input hundreds,
        input tens,
        input ones
    );

endinterface

//--- hud/levelHud.sv
module levelHud #(
    parameter hudPkg::pixelT LabelX = 267,
    parameter hudPkg::pixelT LabelY = 26,
    parameter hudPkg::pixelT DigitX = 287,
    parameter hudPkg::pixelT DigitY = 24
) (
    scoreIf.viewer              score,
    input  hudPkg::pixelT       PixelX,
    input  hudPkg::pixelT       PixelY,
    output hudPkg::levelT       gameLevel,
    output hudPkg::respawnT     respawnUnitTime,
    output logic                levelHit,
    output hudPkg::spriteAddrT  levelAddress
);

    // level steps up at fixed score thresholds, anything past 99 jumps to 9.
    always_comb begin
        gameLevel = 4'd9;
        if (score.total <= 10'd10) begin
            gameLevel = 4'd1;
        end else if (score.total <= 10'd15) begin
            gameLevel = 4'd2;
        end else if (score.total <= 10'd30) begin
            gameLevel = 4'd3;
        end else if (score.total <= 10'd55) begin
            gameLevel = 4'd4;
        end else if (score.total <= 10'd75) begin
            gameLevel = 4'd5;
        end else if (score.total <= 10'd99) begin
            gameLevel = 4'd6;
        end
    end

    always_comb begin
        case (gameLevel)
            4'd1: respawnUnitTime = 10'd70;
            4'd2: respawnUnitTime = 10'd40;
            4'd3: respawnUnitTime = 10'd25;
            4'd4: respawnUnitTime = 10'd15;
            4'd5: respawnUnitTime = 10'd10;
            4'd6: respawnUnitTime = 10'd5;
            default: respawnUnitTime = 10'd5; // level 9 keeps the fastest pace.
        endcase
    end

    always_comb begin
        levelHit     = 1'b0;
        levelAddress = '0;
        if (hudPkg::inBox(PixelX, PixelY, LabelX, LabelY)) begin
            levelHit     = 1'b1;
            levelAddress = hudPkg::glyphAddr(hudPkg::GlyphL, PixelX - LabelX,
                                             PixelY - LabelY);
        end else if (hudPkg::inBox(PixelX, PixelY, DigitX, DigitY)) begin
            levelHit     = 1'b1; // the level number is its own glyph index.
            levelAddress = hudPkg::glyphAddr(gameLevel, PixelX - DigitX,
                                             PixelY - DigitY);
        end
    end

endmodule

//--- hud/scoreHud.sv
module scoreHud #(
    parameter hudPkg::pixelT ScoreX = 20,
    parameter hudPkg::pixelT ScoreY = 24
) (
    scoreIf.viewer              score,
    input  hudPkg::pixelT       PixelX,
    input  hudPkg::pixelT       PixelY,
    output logic                scoreHit,
    output hudPkg::spriteAddrT  scoreAddress
);

    // the three digit boxes sit side by side with no gap between them.
    localparam hudPkg::pixelT TensX = hudPkg::pixelT'(int'(ScoreX) + hudPkg::GlyphWidth);
    localparam hudPkg::pixelT OnesX = hudPkg::pixelT'(int'(ScoreX) + 2 * hudPkg::GlyphWidth);

    hudPkg::pixelT dy;

    assign dy = PixelY - ScoreY; // all three boxes share one row.

    always_comb begin
        scoreHit     = 1'b0;
        scoreAddress = '0;
        if (hudPkg::inBox(PixelX, PixelY, ScoreX, ScoreY)) begin
            scoreHit     = 1'b1;
            scoreAddress = hudPkg::glyphAddr(score.hundreds, PixelX - ScoreX, dy);
        end else if (hudPkg::inBox(PixelX, PixelY, TensX, ScoreY)) begin
            scoreHit     = 1'b1;
            scoreAddress = hudPkg::glyphAddr(score.tens, PixelX - TensX, dy);
        end else if (hudPkg::inBox(PixelX, PixelY, OnesX, ScoreY)) begin
            scoreHit     = 1'b1;
            scoreAddress = hudPkg::glyphAddr(score.ones, PixelX - OnesX, dy);
        end
    end

endmodule

//--- rtl/enemySpawner.sv
module enemySpawner (
    input  logic            Clk,
    input  logic            arstN,
    input  logic            gameActive,
    input  logic            frameStart,
    input  hudPkg::respawnT respawnUnitTime,
    output logic            spawnPulse
);

    hudPkg::spawnStateT state;
    hudPkg::respawnT    frameCount;
    hudPkg::respawnT    nextCount;

    assign nextCount = frameCount + 10'd1;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state      <= hudPkg::SpawnIdle;
            frameCount <= '0;
            spawnPulse <= 1'b0;
        end else begin
            spawnPulse <= 1'b0;
            case (state)
                hudPkg::SpawnIdle: begin
                    frameCount <= '0;
                    if (gameActive) begin
                        state <= hudPkg::SpawnCount;
                    end
                end
                hudPkg::SpawnCount: begin
                    if (!gameActive) begin
                        state      <= hudPkg::SpawnIdle;
                        frameCount <= '0;
                    end else if (frameStart) begin
                        // "or more" so a shorter interval after a level rise fires at once.
                        if (nextCount >= respawnUnitTime) begin
                            spawnPulse <= 1'b1;
                            frameCount <= '0;
                        end else begin
                            frameCount <= nextCount;
                        end
                    end
                end
                default: begin
                    state      <= hudPkg::SpawnIdle;
                    frameCount <= '0;
                end
            endcase
        end
    end

    // spawns are at least one frame apart, never back to back.
    aSinglePulse: assert property (@(posedge Clk) disable iff (!arstN)
        spawnPulse |=> !spawnPulse);

endmodule

//--- rtl/gameHudTop.sv
module gameHudTop #(
    parameter hudPkg::pixelT LabelX = 267,
    parameter hudPkg::pixelT LabelY = 26,
    parameter hudPkg::pixelT DigitX = 287,
    parameter hudPkg::pixelT DigitY = 24,
    parameter hudPkg::pixelT ScoreX = 20,
    parameter hudPkg::pixelT ScoreY = 24
) (
    input  logic               Clk,
    input  logic               arstN,
    input  hudPkg::pixelT      PixelX,
    input  hudPkg::pixelT      PixelY,
    input  logic               pointsValid,
    input  hudPkg::pointsT     points,
    input  logic               frameStart,
    input  logic               gameActive,
    output logic               isObj,
    output hudPkg::spriteAddrT objAddress,
    output hudPkg::levelT      gameLevel,
    output hudPkg::respawnT    respawnUnitTime,
    output hudPkg::scoreT      scoreTotal,
    output logic               spawnPulse
);

    logic               levelHit;
    hudPkg::spriteAddrT levelAddress;
    logic               scoreHit;
    hudPkg::spriteAddrT scoreAddress;

    scoreIf score ();

    assign scoreTotal = score.total;

    scoreKeeper uScoreKeeper (
        .Clk         (Clk),
        .arstN       (arstN),
        .pointsValid (pointsValid),
        .points      (points),
        .score       (score.keeper)
    );

    levelHud #(
        .LabelX (LabelX),
        .LabelY (LabelY),
        .DigitX (DigitX),
        .DigitY (DigitY)
    ) uLevelHud (
        .score           (score.viewer),
        .PixelX          (PixelX),
        .PixelY          (PixelY),
        .gameLevel       (gameLevel),
        .respawnUnitTime (respawnUnitTime),
        .levelHit        (levelHit),
        .levelAddress    (levelAddress)
    );

    scoreHud #(
        .ScoreX (ScoreX),
        .ScoreY (ScoreY)
    ) uScoreHud (
        .score        (score.viewer),
        .PixelX       (PixelX),
        .PixelY       (PixelY),
        .scoreHit     (scoreHit),
        .scoreAddress (scoreAddress)
    );

    enemySpawner uEnemySpawner (
        .Clk             (Clk),
        .arstN           (arstN),
        .gameActive      (gameActive),
        .frameStart      (frameStart),
        .respawnUnitTime (respawnUnitTime),
        .spawnPulse      (spawnPulse)
    );

    hudOverlay uHudOverlay (
        .Clk          (Clk),
        .arstN        (arstN),
        .levelHit     (levelHit),
        .levelAddress (levelAddress),
        .scoreHit     (scoreHit),
        .scoreAddress (scoreAddress),
        .isObj        (isObj),
        .objAddress   (objAddress)
    );

endmodule

//--- rtl/hudOverlay.sv
module hudOverlay (
    input  logic               Clk,
    input  logic               arstN,
    input  logic               levelHit,
    input  hudPkg::spriteAddrT levelAddress,
    input  logic               scoreHit,
    input  hudPkg::spriteAddrT scoreAddress,
    output logic               isObj,
    output hudPkg::spriteAddrT objAddress
);

    logic               mergedHit;
    hudPkg::spriteAddrT mergedAddress;

    // level glyphs win where the two areas would overlap.
    always_comb begin
        mergedHit     = levelHit | scoreHit;
        mergedAddress = '0;
        if (levelHit) begin
            mergedAddress = levelAddress;
        end else if (scoreHit) begin
            mergedAddress = scoreAddress;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            isObj      <= 1'b0;
            objAddress <= '0;
        end else begin
            isObj      <= mergedHit;
            objAddress <= mergedAddress;
        end
    end

    // only glyphs 0 to 10 exist in the ROM.
    aAddrInRom: assert property (@(posedge Clk) disable iff (!arstN)
        isObj |-> int'(objAddress) < (int'(hudPkg::GlyphL) + 1) * hudPkg::GlyphSize);

endmodule

//--- rtl/scoreKeeper.sv
module scoreKeeper (
    input  logic           Clk,
    input  logic           arstN,
    input  logic           pointsValid,
    input  hudPkg::pointsT points,
    scoreIf.keeper         score
);

    logic [10:0]      sumWide;
    logic [4:0]       onesSum;
    logic [4:0]       tensSum;
    logic [1:0]       onesCarry;
    logic             tensCarry;
    hudPkg::bcdDigitT onesNext;
    hudPkg::bcdDigitT tensNext;
    hudPkg::bcdDigitT hundredsNext;

    // BCD add in step with the binary one, so the HUD never has to divide.
    always_comb begin
        sumWide = {1'b0, score.total} + {7'd0, points};
        onesSum = {1'b0, score.ones} + {1'b0, points};
        if (onesSum >= 5'd20) begin
            onesNext  = hudPkg::bcdDigitT'(onesSum - 5'd20);
            onesCarry = 2'd2;
        end else if (onesSum >= 5'd10) begin
            onesNext  = hudPkg::bcdDigitT'(onesSum - 5'd10);
            onesCarry = 2'd1;
        end else begin
            onesNext  = hudPkg::bcdDigitT'(onesSum);
            onesCarry = 2'd0;
        end
        tensSum = {1'b0, score.tens} + {3'd0, onesCarry};
        if (tensSum >= 5'd10) begin
            tensNext  = hudPkg::bcdDigitT'(tensSum - 5'd10);
            tensCarry = 1'b1;
        end else begin
            tensNext  = hudPkg::bcdDigitT'(tensSum);
            tensCarry = 1'b0;
        end
        hundredsNext = score.hundreds + {3'd0, tensCarry}; // below 999 this cannot pass 9.
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            score.total    <= '0;
            score.hundreds <= '0;
            score.tens     <= '0;
            score.ones     <= '0;
        end else if (pointsValid) begin
            if (sumWide >= 11'(hudPkg::MaxScore)) begin
                score.total    <= hudPkg::scoreT'(hudPkg::MaxScore);
                score.hundreds <= 4'd9;
                score.tens     <= 4'd9;
                score.ones     <= 4'd9;
            end else begin
                score.total    <= hudPkg::scoreT'(sumWide);
                score.hundreds <= hundredsNext;
                score.tens     <= tensNext;
                score.ones     <= onesNext;
            end
        end
    end

    aDigitsValid: assert property (@(posedge Clk) disable iff (!arstN)
        score.hundreds <= 4'd9 && score.tens <= 4'd9 && score.ones <= 4'd9 &&
        int'(score.total) <= hudPkg::MaxScore);

    // the decimal copy must always spell the binary total.
    aDigitsMatch: assert property (@(posedge Clk) disable iff (!arstN)
        int'(score.total) == int'(score.hundreds) * 100 + int'(score.tens) * 10 +
                             int'(score.ones));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the HUD testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tbGameHud -o simGameHud

status=0
./obj_dir/simGameHud > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

//--- sim/tbGameHud.sv
module tbGameHud;
    timeunit 1ns;
    timeprecision 1ps;

    // HUD geometry as the top level places it.
    localparam int LabelX   = 267;
    localparam int LabelY   = 26;
    localparam int DigitX   = 287;
    localparam int DigitY   = 24;
    localparam int ScoreX   = 20;
    localparam int ScoreY   = 24;
    localparam int BoxW     = 20;
    localparam int BoxH     = 25;
    localparam int BoxSize  = 500;
    localparam int MaxScore = 999;

    logic               Clk;
    logic               arstN;
    hudPkg::pixelT      PixelX;
    hudPkg::pixelT      PixelY;
    logic               pointsValid;
    hudPkg::pointsT     points;
    logic               frameStart;
    logic               gameActive;
    logic               isObj;
    hudPkg::spriteAddrT objAddress;
    hudPkg::levelT      gameLevel;
    hudPkg::respawnT    respawnUnitTime;
    hudPkg::scoreT      scoreTotal;
    logic               spawnPulse;

    int    errorCount;
    int    testCount;
    int    modelScore;
    string rowName[$];
    int    rowPoints[$];
    int    rowX[$];
    int    rowY[$];

    gameHudTop uut (
        .Clk             (Clk),
        .arstN           (arstN),
        .PixelX          (PixelX),
        .PixelY          (PixelY),
        .pointsValid     (pointsValid),
        .points          (points),
        .frameStart      (frameStart),
        .gameActive      (gameActive),
        .isObj           (isObj),
        .objAddress      (objAddress),
        .gameLevel       (gameLevel),
        .respawnUnitTime (respawnUnitTime),
        .scoreTotal      (scoreTotal),
        .spawnPulse      (spawnPulse)
    );

    always #10 Clk = ~Clk;

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    function automatic int levelOf(input int s);
        if (s <= 10) return 1;
        else if (s <= 15) return 2;
        else if (s <= 30) return 3;
        else if (s <= 55) return 4;
        else if (s <= 75) return 5;
        else if (s <= 99) return 6;
        return 9;
    endfunction

    function automatic int respawnOf(input int level);
        case (level)
            1: return 70;
            2: return 40;
            3: return 25;
            4: return 15;
            5: return 10;
            default: return 5;
        endcase
    endfunction

    function automatic bit insideBox(input int x, input int y, input int x0, input int y0);
        return x >= x0 && x < x0 + BoxW && y >= y0 && y < y0 + BoxH;
    endfunction

    // expected glyph hit and ROM address for one pixel at a given score.
    task automatic glyphModel(input int s, input int x, input int y,
                              output bit hit, output int addr);
        int glyph;
        int x0;
        int y0;
        hit = 1'b1;
        glyph = 0;
        x0 = ScoreX;
        y0 = ScoreY;
        if (insideBox(x, y, LabelX, LabelY)) begin
            glyph = 10;
            x0 = LabelX;
            y0 = LabelY;
        end else if (insideBox(x, y, DigitX, DigitY)) begin
            glyph = levelOf(s);
            x0 = DigitX;
            y0 = DigitY;
        end else if (insideBox(x, y, ScoreX, ScoreY)) begin
            glyph = s / 100;
        end else if (insideBox(x, y, ScoreX + BoxW, ScoreY)) begin
            glyph = (s / 10) % 10;
            x0 = ScoreX + BoxW;
        end else if (insideBox(x, y, ScoreX + 2 * BoxW, ScoreY)) begin
            glyph = s % 10;
            x0 = ScoreX + 2 * BoxW;
        end else begin
            hit = 1'b0;
        end
        addr = hit ? glyph * BoxSize + (y - y0) * BoxW + (x - x0) : 0;
    endtask

    task automatic addRow(input string name, input int p, input int x, input int y);
        rowName.push_back(name);
        rowPoints.push_back(p);
        rowX.push_back(x);
        rowY.push_back(y);
    endtask

    // points and a glyph pixel stay live while reset is low, so only the reset holds zero.
    task automatic applyReset();
        arstN       = 1'b0;
        pointsValid = 1'b1;
        points      = hudPkg::pointsT'(5);
        PixelX      = hudPkg::pixelT'(LabelX);
        PixelY      = hudPkg::pixelT'(LabelY);
        repeat (3) @(negedge Clk);
        arstN       = 1'b1;
        pointsValid = 1'b0;
        points      = '0;
        PixelX      = '0;
        PixelY      = '0;
        modelScore = 0;
    endtask

    task automatic awardPoints(input int p);
        @(negedge Clk);
        pointsValid = 1'b1;
        points      = hudPkg::pointsT'(p);
        @(negedge Clk);
        pointsValid = 1'b0;
        modelScore = (modelScore + p > MaxScore) ? MaxScore : modelScore + p;
    endtask

    // the pixel is set one cycle before the check, which is the overlay latency.
    task automatic applyRow(input string name, input int p, input int x, input int y);
        bit hit;
        int addr;
        awardPoints(p);
        PixelX = hudPkg::pixelT'(x);
        PixelY = hudPkg::pixelT'(y);
        @(negedge Clk);
        glyphModel(modelScore, x, y, hit, addr);
        checkValue({name, " score"}, modelScore, int'(scoreTotal));
        checkValue({name, " level"}, levelOf(modelScore), int'(gameLevel));
        checkValue({name, " respawn"}, respawnOf(levelOf(modelScore)), int'(respawnUnitTime));
        checkValue({name, " isObj"}, int'(hit), int'(isObj));
        checkValue({name, " objAddress"}, addr, int'(objAddress));
    endtask

    task automatic sendFrame(output bit spawned);
        @(negedge Clk);
        frameStart = 1'b1;
        @(negedge Clk);
        frameStart = 1'b0;
        spawned = spawnPulse; // registered at the edge that saw the frame.
    endtask

    task automatic waitForSpawn(input string name, input int limit, output int frames);
        bit spawned;
        bit done;
        frames = 0;
        done   = 1'b0;
        while (!done && frames < limit) begin
            sendFrame(spawned);
            frames++;
            done = spawned;
        end
        if (!done) begin
            $display("%s: timed out, no spawn pulse within %0d frames", name, limit);
            errorCount++;
        end
    endtask

    task automatic countSpawns(input int count, output int spawns);
        bit spawned;
        spawns = 0;
        for (int i = 0; i < count; i++) begin
            sendFrame(spawned);
            spawns += int'(spawned);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        $display("test %-24s %s", name, (errorCount == errBefore) ? "passed" : "failed");
    endtask

    initial begin
        int errBefore;
        int frames;
        int spawns;
        Clk         = 1'b0;
        arstN       = 1'b0;
        PixelX      = '0;
        PixelY      = '0;
        pointsValid = 1'b0;
        points      = '0;
        frameStart  = 1'b0;
        gameActive  = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        modelScore  = 0;
        void'($urandom(87));

        // each row adds points and lands on a level boundary or a glyph edge.
        addRow("level 1 at 10", 10, 267, 26);
        addRow("level 2 at 11", 1, 287, 24);
        addRow("level 2 at 15", 4, 290, 30);
        addRow("level 3 at 16", 1, 306, 48);
        addRow("level 3 at 30", 14, 20, 24);
        addRow("level 4 at 31", 1, 45, 30);
        addRow("step to 46", 15, 150, 30);
        addRow("level 4 at 55", 9, 79, 48);
        addRow("level 5 at 56", 1, 80, 30);
        addRow("step to 71", 15, 270, 51);
        addRow("level 5 at 75", 4, 286, 50);
        addRow("level 6 at 76", 1, 290, 23);
        addRow("step to 91", 15, 300, 40);
        addRow("level 6 at 99", 8, 65, 35);
        addRow("level 9 at 100", 1, 25, 30);
        addRow("no points", 0, 19, 24);

        errBefore = errorCount;
        applyReset();
        checkValue("reset isObj", 0, int'(isObj));
        checkValue("reset objAddress", 0, int'(objAddress));
        checkValue("reset spawnPulse", 0, int'(spawnPulse));
        checkValue("reset scoreTotal", 0, int'(scoreTotal));
        reportTest("reset", errBefore);

        errBefore = errorCount;
        @(negedge Clk);
        gameActive = 1'b1;
        @(negedge Clk); // the spawner starts counting after this edge.
        waitForSpawn("spawn at level 1", 200, frames);
        checkValue("spawn at level 1 frames", respawnOf(levelOf(modelScore)), frames);
        reportTest("spawn at level 1", errBefore);

        errBefore = errorCount;
        countSpawns(30, spawns);
        checkValue("interval drop early spawns", 0, spawns);
        awardPoints(15);
        awardPoints(1); // score 16 cuts the interval to 25, below the 30 counted.
        waitForSpawn("interval drop", 10, frames);
        checkValue("interval drop frames", 1, frames);
        reportTest("interval drop", errBefore);

        errBefore = errorCount;
        @(negedge Clk);
        gameActive = 1'b0;
        countSpawns(100, spawns);
        checkValue("inactive spawns", 0, spawns);
        reportTest("inactive", errBefore);

        applyReset();
        for (int i = 0; i < rowName.size(); i++) begin
            errBefore = errorCount;
            applyRow(rowName[i], rowPoints[i], rowX[i], rowY[i]);
            reportTest(rowName[i], errBefore);
        end

        errBefore = errorCount;
        for (int i = 0; i < 200; i++) begin
            applyRow("random award", int'($urandom % 16), int'($urandom % 320),
                     20 + int'($urandom % 32));
        end
        reportTest("random awards", errBefore);

        errBefore = errorCount;
        applyRow("saturation", 15, 65, 30);
        checkValue("saturation total", MaxScore, int'(scoreTotal));
        reportTest("saturation", errBefore);

        $display("tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/hudPkg.sv
common/scoreIf.sv
hud/levelHud.sv
hud/scoreHud.sv
rtl/scoreKeeper.sv
rtl/enemySpawner.sv
rtl/hudOverlay.sv
rtl/gameHudTop.sv
sim/tbGameHud.sv
